/* run.sh */
#!/bin/bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fpu_request_ctrl \
	--Mdir obj_dir -o tb_sim \
	-f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation run returned status $run_status"
	exit 1
fi

grep -q "Simulation completed successfully" sim.log
if [ $? -ne 0 ]; then
	echo "Pass message not found in sim.log"
	exit 1
fi

exit 0

/* sim.f */
src/fpu_mem_pkg.sv
src/fpu_buf_pkg.sv
src/line_fetch.sv
src/line_pack.sv
src/dram_port_arb.sv
src/fpu_request_ctrl.sv
tb/fpu_request_ctrl_assert.sv
tb/tb_fpu_request_ctrl.sv

/* src/dram_port_arb.sv */
`timescale 1ns/1ns

module dram_port_arb (
	input  logic clk,
	input  logic rst_n,
	input  logic fetch_request,
	input  fpu_mem_pkg::addr_t fetch_addr,
	input  logic fetch_fpu_ready,
	input  logic pack_request,
	input  fpu_mem_pkg::addr_t pack_addr,
	input  fpu_mem_pkg::lines_t pack_size,
	input  logic pack_fpu_ready,
	input  fpu_mem_pkg::cl_t pack_write_data,
	input  logic dram_ready,
	input  logic request_done,
	output logic fetch_dram_ready,
	output logic fetch_done,
	output logic pack_dram_ready,
	output logic pack_done,
	output logic dram_request,
	output fpu_mem_pkg::addr_t dram_addr,
	output logic dram_rd_wr,
	output fpu_mem_pkg::lines_t dram_size,
	output logic fpu_ready,
	output fpu_mem_pkg::cl_t dram_write_data
);
	import fpu_mem_pkg::*;

	logic granted;
	logic owner; // 1 = pack, kept after release as last owner
	logic fetch_pend;
	logic pack_pend;
	logic fetch_want;
	logic pack_want;
	logic pick;
	logic issue;
	logic sel;

	assign fetch_want = fetch_request || fetch_pend;
	assign pack_want = pack_request || pack_pend;
	assign pick = (fetch_want && pack_want) ? ~owner : pack_want; // alternate on a tie
	assign issue = !granted && (fetch_want || pack_want);
	assign sel = granted ? owner : pick;

	assign dram_request = issue;
	assign dram_addr = sel ? pack_addr : fetch_addr;
	assign dram_rd_wr = sel;
	assign dram_size = sel ? pack_size : LINES_PER_ROW;
	assign dram_write_data = pack_write_data; // only pack writes

	assign fpu_ready = granted && (owner ? pack_fpu_ready : fetch_fpu_ready);
	assign fetch_dram_ready = granted && !owner && dram_ready;
	assign pack_dram_ready = granted && owner && dram_ready;
	assign fetch_done = granted && !owner && request_done;
	assign pack_done = granted && owner && request_done;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			granted <= 1'b0;
			owner <= 1'b1; // fetch wins the first tie
			fetch_pend <= 1'b0;
			pack_pend <= 1'b0;
		end else begin
			if (issue) begin
				granted <= 1'b1;
				owner <= pick;
			end else if (granted && request_done) begin
				granted <= 1'b0;
			end
			// a loser keeps waiting for the next free cycle
			fetch_pend <= fetch_want && !(issue && !pick);
			pack_pend <= pack_want && !(issue && pick);
		end
	end

endmodule

/* src/fpu_buf_pkg.sv */
package fpu_buf_pkg;

	localparam int BUF_COLS = 64; // words or bytes per row
	localparam int BUF_ROWS = 8;
	localparam int COL_W = $clog2(BUF_COLS);
	localparam int ROW_W = $clog2(BUF_ROWS);

	typedef logic [63:0] word_t; // input buffer word

	// row sits above column in both buffers
	typedef logic [ROW_W+COL_W-1:0] in_addr_t;
	typedef logic [ROW_W+COL_W-1:0] out_addr_t;

endpackage

/* src/fpu_mem_pkg.sv */
package fpu_mem_pkg;

	localparam int CL_BYTES = 64; // bytes per cache line
	localparam int CL_BITS = CL_BYTES * 8;

	typedef logic [31:0] addr_t; // dram byte address
	typedef logic [CL_BITS-1:0] cl_t; // byte 0 in the top 8 bits
	typedef logic [7:0] byte_t;
	typedef logic [16:0] dim_t; // width or height count
	typedef logic [7:0] lines_t; // lines per request

	localparam lines_t LINES_PER_ROW = 8; // one fetched row is 512 bytes

	// lines needed to cover a row of the given width in bytes
	function automatic lines_t lines_for_width(dim_t width);
		dim_t full;
		dim_t part;
		full = width >> $clog2(CL_BYTES);
		part = dim_t'(|width[$clog2(CL_BYTES)-1:0]);
		return lines_t'(full + part);
	endfunction

endpackage

/* src/fpu_request_ctrl.sv */
`timescale 1ns/1ns

module fpu_request_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic fetch_start,
	input  fpu_mem_pkg::addr_t fetch_addr,
	input  fpu_mem_pkg::addr_t fetch_stride,
	input  fpu_mem_pkg::dim_t fetch_rows,
	output logic fetch_busy,
	input  logic store_start,
	input  fpu_mem_pkg::addr_t store_addr,
	input  fpu_mem_pkg::dim_t store_width,
	input  fpu_mem_pkg::dim_t store_rows,
	output logic store_busy,
	output logic dram_request,
	output fpu_mem_pkg::addr_t dram_addr,
	output logic dram_rd_wr,
	output fpu_mem_pkg::lines_t dram_size,
	input  logic dram_ready,
	output logic fpu_ready,
	output fpu_mem_pkg::cl_t dram_write_data,
	input  fpu_mem_pkg::cl_t dram_read_data,
	input  logic request_done,
	output logic in_wr_en,
	output fpu_buf_pkg::in_addr_t in_wr_addr,
	output fpu_buf_pkg::word_t in_wr_data,
	output fpu_buf_pkg::out_addr_t out_rd_addr,
	input  fpu_mem_pkg::byte_t out_rd_data
);
	import fpu_mem_pkg::*;

	logic f_request;
	addr_t f_addr;
	logic f_fpu_ready;
	logic f_dram_ready;
	logic f_done;
	logic p_request;
	addr_t p_addr;
	lines_t p_size;
	logic p_fpu_ready;
	cl_t p_write_data;
	logic p_dram_ready;
	logic p_done;

	line_fetch u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_start(fetch_start),
		.fetch_addr(fetch_addr),
		.fetch_stride(fetch_stride),
		.fetch_rows(fetch_rows),
		.dram_ready(f_dram_ready),
		.request_done(f_done),
		.read_data(dram_read_data), // no routing needed for reads
		.fetch_busy(fetch_busy),
		.request(f_request),
		.addr(f_addr),
		.fpu_ready(f_fpu_ready),
		.in_wr_en(in_wr_en),
		.in_wr_addr(in_wr_addr),
		.in_wr_data(in_wr_data)
	);

	line_pack u_pack (
		.clk(clk),
		.rst_n(rst_n),
		.store_start(store_start),
		.store_addr(store_addr),
		.store_width(store_width),
		.store_rows(store_rows),
		.dram_ready(p_dram_ready),
		.request_done(p_done),
		.out_rd_data(out_rd_data),
		.store_busy(store_busy),
		.request(p_request),
		.addr(p_addr),
		.size(p_size),
		.fpu_ready(p_fpu_ready),
		.write_data(p_write_data),
		.out_rd_addr(out_rd_addr)
	);

	dram_port_arb u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_request(f_request),
		.fetch_addr(f_addr),
		.fetch_fpu_ready(f_fpu_ready),
		.pack_request(p_request),
		.pack_addr(p_addr),
		.pack_size(p_size),
		.pack_fpu_ready(p_fpu_ready),
		.pack_write_data(p_write_data),
		.dram_ready(dram_ready),
		.request_done(request_done),
		.fetch_dram_ready(f_dram_ready),
		.fetch_done(f_done),
		.pack_dram_ready(p_dram_ready),
		.pack_done(p_done),
		.dram_request(dram_request),
		.dram_addr(dram_addr),
		.dram_rd_wr(dram_rd_wr),
		.dram_size(dram_size),
		.fpu_ready(fpu_ready),
		.dram_write_data(dram_write_data)
	);

endmodule

/* src/line_fetch.sv */
`timescale 1ns/1ns

module line_fetch (
	input  logic clk,
	input  logic rst_n,
	input  logic fetch_start,
	input  fpu_mem_pkg::addr_t fetch_addr,
	input  fpu_mem_pkg::addr_t fetch_stride,
	input  fpu_mem_pkg::dim_t fetch_rows,
	input  logic dram_ready,
	input  logic request_done,
	input  fpu_mem_pkg::cl_t read_data,
	output logic fetch_busy,
	output logic request,
	output fpu_mem_pkg::addr_t addr,
	output logic fpu_ready,
	output logic in_wr_en,
	output fpu_buf_pkg::in_addr_t in_wr_addr,
	output fpu_buf_pkg::word_t in_wr_data
);
	import fpu_mem_pkg::*;
	import fpu_buf_pkg::*;

	typedef enum logic [2:0] {
		F_IDLE,
		F_REQ,
		F_WAIT_LINE,
		F_UNPACK,
		F_WAIT_DONE
	} fetch_state_e;

	fetch_state_e state;

	addr_t stride;
	dim_t rows_left;
	logic [ROW_W-1:0] buf_row;
	logic [COL_W-1:0] col_base; // first column of the current line
	logic [2:0] word_cnt;
	logic done_seen;
	logic beat;
	logic row_done;
	cl_t line;

	assign fetch_busy = state != F_IDLE;
	assign request = state == F_REQ;
	assign fpu_ready = state == F_WAIT_LINE;
	assign beat = fpu_ready && dram_ready;
	assign row_done = request_done || done_seen;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= F_IDLE;
			addr <= '0;
			stride <= '0;
			rows_left <= '0;
			buf_row <= '0;
			col_base <= '0;
			word_cnt <= '0;
			done_seen <= 1'b0;
			in_wr_en <= 1'b0;
		end else begin
			in_wr_en <= 1'b0;
			case (state)
				F_IDLE: if (fetch_start && fetch_rows != '0) begin
					state <= F_REQ;
					addr <= fetch_addr;
					stride <= fetch_stride;
					rows_left <= fetch_rows;
					buf_row <= '0;
				end
				F_REQ: begin
					state <= F_WAIT_LINE;
					col_base <= '0;
				end
				F_WAIT_LINE: if (beat) begin
					state <= F_UNPACK;
					word_cnt <= '0;
				end
				F_UNPACK: begin
					in_wr_en <= 1'b1;
					word_cnt <= word_cnt + 3'd1;
					if (&word_cnt) begin // last word of the line
						col_base <= col_base + COL_W'(8);
						if (col_base == COL_W'(BUF_COLS - 8))
							state <= F_WAIT_DONE;
						else
							state <= F_WAIT_LINE;
					end
				end
				F_WAIT_DONE: if (row_done) begin
					if (rows_left == dim_t'(1)) begin
						state <= F_IDLE;
					end else begin
						state <= F_REQ;
						addr <= addr + stride;
						rows_left <= rows_left - dim_t'(1);
						buf_row <= buf_row + 1'b1;
					end
				end
				default: state <= F_IDLE;
			endcase

			// done may arrive while the last line is still unpacking
			if (state == F_REQ)
				done_seen <= 1'b0;
			else if (request_done)
				done_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (beat)
			line <= read_data;
		else if (state == F_UNPACK)
			line <= line << $bits(word_t); // msw first
		in_wr_data <= line[$bits(cl_t)-1 -: $bits(word_t)];
		in_wr_addr <= {buf_row, col_base + COL_W'(word_cnt)};
	end

endmodule

/* src/line_pack.sv */
`timescale 1ns/1ns

module line_pack (
	input  logic clk,
	input  logic rst_n,
	input  logic store_start,
	input  fpu_mem_pkg::addr_t store_addr,
	input  fpu_mem_pkg::dim_t store_width,
	input  fpu_mem_pkg::dim_t store_rows,
	input  logic dram_ready,
	input  logic request_done,
	input  fpu_mem_pkg::byte_t out_rd_data,
	output logic store_busy,
	output logic request,
	output fpu_mem_pkg::addr_t addr,
	output fpu_mem_pkg::lines_t size,
	output logic fpu_ready,
	output fpu_mem_pkg::cl_t write_data,
	output fpu_buf_pkg::out_addr_t out_rd_addr
);
	import fpu_mem_pkg::*;
	import fpu_buf_pkg::*;

	typedef enum logic [2:0] {
		P_IDLE,
		P_REQ,
		P_LOAD,
		P_OFFER,
		P_WAIT_DONE
	} pack_state_e;

	pack_state_e state;

	lines_t lines;
	lines_t lines_sent;
	dim_t rows_left;
	logic [ROW_W-1:0] rd_row;
	logic [COL_W-1:0] rd_col;
	logic [$clog2(CL_BYTES):0] load_cnt; // top bit set after 64 reads
	logic done_seen;
	logic beat;
	logic row_done;

	assign store_busy = state != P_IDLE;
	assign request = state == P_REQ;
	assign fpu_ready = state == P_OFFER;
	assign size = lines;
	assign out_rd_addr = {rd_row, rd_col};
	assign beat = fpu_ready && dram_ready;
	assign row_done = request_done || done_seen;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= P_IDLE;
			addr <= '0;
			lines <= '0;
			lines_sent <= '0;
			rows_left <= '0;
			rd_row <= '0;
			rd_col <= '0;
			load_cnt <= '0;
			done_seen <= 1'b0;
		end else begin
			case (state)
				P_IDLE: if (store_start && store_width != '0 && store_rows != '0) begin
					state <= P_REQ;
					addr <= store_addr;
					lines <= lines_for_width(store_width);
					rows_left <= store_rows;
					rd_row <= '0;
				end
				P_REQ: begin
					state <= P_LOAD;
					load_cnt <= '0;
					rd_col <= '0;
					lines_sent <= '0;
				end
				P_LOAD: begin
					load_cnt <= load_cnt + 1'b1;
					if (!load_cnt[$clog2(CL_BYTES)])
						rd_col <= rd_col + 1'b1; // wraps back to col 0
					else
						state <= P_OFFER;
				end
				P_OFFER: if (beat) begin
					lines_sent <= lines_sent + lines_t'(1);
					if (lines_sent == lines - lines_t'(1)) begin
						state <= P_WAIT_DONE;
					end else begin
						state <= P_LOAD;
						load_cnt <= '0;
					end
				end
				P_WAIT_DONE: if (row_done) begin
					if (rows_left == dim_t'(1)) begin
						state <= P_IDLE;
					end else begin
						state <= P_REQ;
						addr <= addr + addr_t'(lines) * CL_BYTES;
						rows_left <= rows_left - dim_t'(1);
						rd_row <= rd_row + 1'b1;
					end
				end
				default: state <= P_IDLE;
			endcase

			if (state == P_REQ)
				done_seen <= 1'b0;
			else if (request_done)
				done_seen <= 1'b1;
		end
	end

	// first data lands one cycle after the first address
	always_ff @(posedge clk) begin
		if (state == P_LOAD && load_cnt != '0)
			write_data <= (write_data << $bits(byte_t)) | cl_t'(out_rd_data);
	end

endmodule

/* tb/fpu_request_ctrl_assert.sv */
`timescale 1ns/1ns

module fpu_request_ctrl_assert (
	input logic clk,
	input logic rst_n,
	input logic fetch_request,
	input logic pack_request,
	input logic request_done,
	input logic granted,
	input logic owner,
	input fpu_mem_pkg::addr_t dram_addr,
	input logic dram_rd_wr
);

	// the owning engine asks again only after its done
	assert property (@(posedge clk) disable iff (!rst_n)
		granted |-> !(owner ? pack_request : fetch_request))
		else $error("request raised while its engine holds the grant");

	assert property (@(posedge clk) disable iff (!rst_n) request_done |-> granted)
		else $error("request_done without an outstanding request");

	// direction and address stay put until done
	assert property (@(posedge clk) disable iff (!rst_n)
		granted && !request_done |=> $stable(dram_rd_wr) && $stable(dram_addr))
		else $error("grant changed before request_done");

endmodule

bind dram_port_arb fpu_request_ctrl_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.fetch_request(fetch_request),
	.pack_request(pack_request),
	.request_done(request_done),
	.granted(granted),
	.owner(owner),
	.dram_addr(dram_addr),
	.dram_rd_wr(dram_rd_wr)
);

/* tb/tb_fpu_request_ctrl.sv */
`timescale 1ns/1ns

module tb_fpu_request_ctrl;
	import fpu_mem_pkg::*;
	import fpu_buf_pkg::*;

	localparam int M_IDLE = 0;
	localparam int M_XFER = 1;
	localparam int M_TAIL = 2;
	localparam int M_DONE = 3;

	logic clk;
	logic rst_n;
	logic fetch_start;
	addr_t fetch_addr;
	addr_t fetch_stride;
	dim_t fetch_rows;
	logic store_start;
	addr_t store_addr;
	dim_t store_width;
	dim_t store_rows;
	logic dram_ready = 1'b0;
	logic request_done = 1'b0;
	cl_t dram_read_data = '0;
	byte_t out_rd_data = '0;
	logic fetch_busy;
	logic store_busy;
	logic dram_request;
	addr_t dram_addr;
	logic dram_rd_wr;
	lines_t dram_size;
	logic fpu_ready;
	cl_t dram_write_data;
	logic in_wr_en;
	in_addr_t in_wr_addr;
	word_t in_wr_data;
	out_addr_t out_rd_addr;

	integer seed;
	byte_t dram_mem [addr_t]; // sparse and filled on first read
	byte_t out_buf [0:511];
	word_t in_buf [0:511];
	int wr_hits [0:511];
	out_addr_t rd_addr_q = '0;
	int errors = 0;
	int checks = 0;
	int fetch_writes;
	int fetch_reqs;
	int store_reqs;
	int store_beats;
	logic [7:0] req_order; // 1 = write request
	int stall_mod;
	int done_max;
	bit timed_out = 1'b0;
	addr_t exp_f_addr;
	addr_t exp_f_stride;
	addr_t exp_s_addr;
	lines_t exp_s_lines;
	int m_state = M_IDLE;
	addr_t m_addr;
	logic m_wr;
	lines_t m_size;
	int m_beats;
	int m_delay;

	fpu_request_ctrl UUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(string name, logic [511:0] exp, logic [511:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	function automatic byte_t dram_byte(addr_t a);
		if (!dram_mem.exists(a))
			dram_mem[a] = byte_t'($random(seed));
		return dram_mem[a];
	endfunction

	function automatic cl_t read_line(addr_t a);
		cl_t l;
		for (int i = 0; i < 64; i++)
			l[511-8*i -: 8] = dram_byte(a + addr_t'(i)); // byte 0 on top
		return l;
	endfunction

	// big-endian word of the row fetched from dram
	function automatic word_t expected_in_word(int row, int col);
		word_t w;
		addr_t base;
		base = exp_f_addr + addr_t'(row) * exp_f_stride + addr_t'(col * 8);
		for (int k = 0; k < 8; k++)
			w = {w[55:0], dram_byte(base + addr_t'(k))};
		return w;
	endfunction

	function automatic byte_t expected_dram_byte(int row, int idx);
		return out_buf[row * 64 + idx % 64]; // every line of a row repeats the row
	endfunction

	function automatic lines_t lines_needed(int width);
		return lines_t'((width + 63) / 64);
	endfunction

	// dram model that decides ready and sees each beat before the edge
	always @(negedge clk) begin : dram_model
		cl_t exp_line;
		if (!rst_n) begin
			m_state = M_IDLE;
			dram_ready = 1'b0;
			request_done = 1'b0;
		end else begin
			dram_ready = 1'b0;
			if (m_state == M_DONE) begin
				request_done = 1'b0;
				m_state = M_IDLE;
			end
			if (dram_request) begin
				if (m_state != M_IDLE) begin
					errors++;
					$display("DRAM request arrived while a transfer was still active");
				end
				m_addr = dram_addr;
				m_wr = dram_rd_wr;
				m_size = dram_size;
				req_order = {req_order[6:0], dram_rd_wr};
				m_beats = 0;
				m_delay = 1 + $unsigned($random(seed)) % 4;
				m_state = M_XFER;
				if (m_wr) begin
					check_value("store_req_addr",
						exp_s_addr + addr_t'(store_reqs * exp_s_lines * 64), dram_addr);
					check_value("store_req_size", exp_s_lines, dram_size);
					store_reqs++;
				end else begin
					check_value("fetch_req_addr",
						exp_f_addr + addr_t'(fetch_reqs) * exp_f_stride, dram_addr);
					check_value("fetch_req_size", 8, dram_size);
					fetch_reqs++;
				end
			end else if (m_state == M_XFER) begin
				if (m_delay > 0) begin
					m_delay--;
				end else begin
					dram_ready = ($unsigned($random(seed)) % stall_mod) != 0;
					if (dram_ready && fpu_ready) begin
						if (m_wr) begin
							for (int i = 0; i < 64; i++)
								exp_line[511-8*i -: 8] = expected_dram_byte(store_reqs - 1, i);
							check_value("store_line", exp_line, dram_write_data);
							store_beats++;
						end else begin
							dram_read_data = read_line(m_addr + addr_t'(m_beats * 64));
						end
						m_beats++;
						if (m_beats == m_size) begin
							m_state = M_TAIL;
							m_delay = 1 + $unsigned($random(seed)) % done_max;
						end
					end
				end
			end else if (m_state == M_TAIL) begin
				if (m_delay > 1) begin
					m_delay--;
				end else begin
					request_done = 1'b1;
					m_state = M_DONE;
				end
			end
		end
	end

	always @(negedge clk) begin // output buffer with a one cycle read
		out_rd_data = out_buf[rd_addr_q];
		rd_addr_q = out_rd_addr;
	end

	always @(negedge clk) begin // input buffer and word compare
		if (rst_n && in_wr_en) begin
			in_buf[in_wr_addr] = in_wr_data;
			wr_hits[in_wr_addr]++;
			fetch_writes++;
			check_value("fetch_word", expected_in_word(in_wr_addr[8:6], in_wr_addr[5:0]),
				in_wr_data);
		end
	end

	task automatic clear_counts();
		fetch_writes = 0;
		fetch_reqs = 0;
		store_reqs = 0;
		store_beats = 0;
		req_order = '0;
		for (int i = 0; i < 512; i++)
			wr_hits[i] = 0;
	endtask

	task automatic set_fetch_cmd(addr_t a, addr_t s, int rows);
		fetch_addr = a;
		fetch_stride = s;
		fetch_rows = dim_t'(rows);
	endtask

	task automatic set_store_cmd(addr_t a, int width, int rows);
		store_addr = a;
		store_width = dim_t'(width);
		store_rows = dim_t'(rows);
	endtask

	task automatic pulse_starts(logic f, logic s);
		@(negedge clk);
		fetch_start = f;
		store_start = s;
		@(negedge clk);
		fetch_start = 1'b0;
		store_start = 1'b0;
	endtask

	task automatic wait_idle(string what);
		int n;
		n = 0;
		while ((fetch_busy || store_busy) && n < 20000) begin
			@(negedge clk);
			n++;
		end
		if (fetch_busy || store_busy) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout while waiting for %s to finish", what);
		end
	endtask

	task automatic check_fetch(string name, int rows);
		int bad;
		bad = 0;
		check_value({name, "_writes"}, rows * 64, fetch_writes);
		for (int i = 0; i < rows * 64; i++) begin
			if (wr_hits[i] != 1)
				bad++;
			check_value({name, "_buf_word"}, expected_in_word(i / 64, i % 64), in_buf[i]);
		end
		check_value({name, "_addr_hits"}, 0, bad); // each word written once
	endtask

	initial begin
		seed = 1;
		rst_n = 1'b0;
		fetch_start = 1'b0;
		store_start = 1'b0;
		set_fetch_cmd('0, '0, 0);
		set_store_cmd('0, 0, 0);
		stall_mod = 4;
		done_max = 4;
		for (int i = 0; i < 512; i++)
			out_buf[i] = byte_t'($random(seed));
		clear_counts();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("reset_outputs", 0,
			{dram_request, fpu_ready, in_wr_en, fetch_busy, store_busy});

		// single fetch of 3 rows
		exp_f_addr = 32'h0000_1000;
		exp_f_stride = 32'h0000_0340;
		set_fetch_cmd(exp_f_addr, exp_f_stride, 3);
		pulse_starts(1'b1, 1'b0);
		wait_idle("fetch of 3 rows");
		check_fetch("fetch3", 3);

		// single store of 2 rows of 100 bytes
		if (!timed_out) begin
			clear_counts();
			exp_s_addr = 32'h0000_8000;
			exp_s_lines = lines_needed(100);
			set_store_cmd(exp_s_addr, 100, 2);
			pulse_starts(1'b0, 1'b1);
			wait_idle("store of 2 rows");
			check_value("store2_beats", 4, store_beats);
			check_value("store2_reqs", 2, store_reqs);
		end

		// both engines together
		if (!timed_out) begin
			clear_counts();
			exp_f_addr = 32'h0002_0000;
			exp_f_stride = 32'h0000_0200;
			exp_s_addr = 32'h0004_0000;
			exp_s_lines = lines_needed(64);
			set_fetch_cmd(exp_f_addr, exp_f_stride, 2);
			set_store_cmd(exp_s_addr, 64, 2);
			pulse_starts(1'b1, 1'b1);
			wait_idle("concurrent fetch and store");
			check_fetch("both_fetch", 2);
			check_value("both_store_beats", 2, store_beats);
			check_value("both_store_reqs", 2, store_reqs);
			// pack owned the port last so fetch wins the tie and turns alternate
			check_value("both_req_order", 4'b0101, req_order[3:0]);
		end

		// heavy stalls and late request_done
		if (!timed_out) begin
			clear_counts();
			stall_mod = 2;
			done_max = 12;
			exp_f_addr = 32'h0006_0040;
			exp_f_stride = 32'h0000_0400;
			set_fetch_cmd(exp_f_addr, exp_f_stride, 4);
			pulse_starts(1'b1, 1'b0);
			wait_idle("stalled fetch");
			check_fetch("stall_fetch", 4);
			stall_mod = 4;
			done_max = 4;
		end

		// second start while busy must be ignored
		if (!timed_out) begin
			clear_counts();
			exp_f_addr = 32'h0009_0000;
			exp_f_stride = 32'h0000_0240;
			set_fetch_cmd(exp_f_addr, exp_f_stride, 2);
			pulse_starts(1'b1, 1'b0);
			repeat (5) @(negedge clk);
			set_fetch_cmd(32'h000a_0000, 32'h0000_0080, 5);
			pulse_starts(1'b1, 1'b0);
			wait_idle("fetch with ignored start");
			check_fetch("busy_start", 2);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
